//--- common/scope_cfg_pkg.sv
// Sizes are fixed at compile time and the register map assumes one 32-bit word per index
package scope_cfg_pkg;

    // Capture geometry, one frame holds an equal share of every channel
    localparam int N_STREAMS       = 4;
    localparam int CHANNEL_SAMPLES = 8;
    localparam int TRANSFER_SIZE   = N_STREAMS * CHANNEL_SAMPLES;
    localparam int LEVEL_WIDTH     = 5;

    // External trigger lines and the width of the index that picks one
    localparam int N_TRIGGERS     = 8;
    localparam int TRIG_SEL_WIDTH = $clog2(N_TRIGGERS);

    // Register bus geometry
    localparam int REG_ADDR_WIDTH = 3;
    localparam int REG_WIDTH      = 32;

    // Register map, one word per index
    localparam logic [REG_ADDR_WIDTH-1:0] REG_BUFFER_SIZE      = 3'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_ENABLE           = 3'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_BASE_ADDR        = 3'd2;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_SELECTED_TRIGGER = 3'd3;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CAPTURE_ACK      = 3'd4;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_SW_TRIGGER       = 3'd5;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_TRIGGER_SAMPLE   = 3'd6;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS           = 3'd7;

    // Capture state, also readable through the status register
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ARMED     = 2'd1,
        TRIGGERED = 2'd2,
        HOLD      = 2'd3
    } trigger_state_t;

    // One register bus cycle, read and write are strobes
    typedef struct packed {
        logic                      write;
        logic                      read;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [REG_WIDTH-1:0]      wdata;
    } reg_bus_t;

endpackage

//--- common/scope_stream_pkg.sv
// Stream beats carry one sample each and the memory port accepts a write every cycle
package scope_stream_pkg;

    localparam int DATA_WIDTH = 16;
    localparam int DEST_WIDTH = 2;
    localparam int ADDR_WIDTH = 32;

    // The dest field holds the channel the sample came from
    typedef struct packed {
        logic [DEST_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0] data;
    } sample_t;

    // Last marks the final sample of a frame
    typedef struct packed {
        logic    valid;
        logic    last;
        sample_t sample;
    } stream_beat_t;

    // Word addressed memory write, taken in the cycle it is presented
    typedef struct packed {
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        sample_t               sample;
    } mem_write_t;

endpackage

//--- dma/buffer_writer.sv
// The memory port never stalls and a capture writes at most one frame from base_addr upward
`timescale 1ns/10ps

module buffer_writer import scope_cfg_pkg::*, scope_stream_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  capture_active,
    input  logic [ADDR_WIDTH-1:0] base_addr,
    input  stream_beat_t          beat_in,
    output mem_write_t            mem,
    output logic                  dma_done
);

    localparam int IDX_WIDTH = $clog2(TRANSFER_SIZE + 1);

    logic [IDX_WIDTH-1:0]  wr_idx;
    logic                  take;
    logic                  we_q;
    logic                  last_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    sample_t               sample_q;

    // Beats are written only while the hub is capturing and the scope is enabled
    assign take = capture_active && enable && beat_in.valid;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_idx   <= '0;
            we_q     <= 1'b0;
            last_q   <= 1'b0;
            dma_done <= 1'b0;
        end else begin
            we_q   <= take;
            last_q <= take && beat_in.last;
            // Done follows the write of the last beat by one cycle
            dma_done <= last_q && enable;
            // The index restarts whenever no capture is running or a frame ends
            if (!capture_active || (take && beat_in.last)) begin
                wr_idx <= '0;
            end else if (take) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // Address and data of the write, meaningful only with we_q
    always_ff @(posedge clock) begin
        if (take) begin
            addr_q   <= base_addr + ADDR_WIDTH'(wr_idx);
            sample_q <= beat_in.sample;
        end
    end

    assign mem = '{we: we_q, addr: addr_q, sample: sample_q};

    // The frame counter must close the frame before the index runs past the buffer
    a_idx_in_buffer: assert property (
        @(posedge clock) disable iff (!rst_n) wr_idx <= IDX_WIDTH'(TRANSFER_SIZE - 1)
    );

endmodule

//--- list.f
+incdir+verif
common/scope_cfg_pkg.sv
common/scope_stream_pkg.sv
verilog/scope_regs.sv
verilog/trigger_hub.sv
verilog/sample_counter.sv
verilog/stream_combiner.sv
dma/buffer_writer.sv
verilog/scope_top.sv
verif/scope_tb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module scope_tb -f list.f -o scope_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/scope_sim > sim.log 2>&1
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "Run passed" || { echo "Run failed"; exit 1; }

//--- verif/scope_checks.svh
// Included inside scope_tb and uses its logs, base address, bus tasks and stop_with_error
`ifndef SCOPE_CHECKS_SVH
`define SCOPE_CHECKS_SVH

// One compare task per result kind, the first mismatch ends the run
task automatic check_mem(input string name, input mem_write_t got, input mem_write_t want);
    if (got !== want) begin
        stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, want));
    end
endtask

task automatic check_reg(input string name, input logic [REG_WIDTH-1:0] got,
                         input logic [REG_WIDTH-1:0] want);
    if (got !== want) begin
        stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, want));
    end
endtask

task automatic check_trig(input string name, input logic [N_TRIGGERS-1:0] got,
                          input logic [N_TRIGGERS-1:0] want);
    if (got !== want) begin
        stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, want));
    end
endtask

task automatic check_state(input string name, input trigger_state_t got,
                           input trigger_state_t want);
    if (got !== want) begin
        stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, want));
    end
endtask

// Writes since the window start must match the expected queue at base upward
task automatic check_frame(input int count);
    mem_write_t want;
    check_reg("write count", REG_WIDTH'(wr_log.size() - wr_start), REG_WIDTH'(count));
    for (int k = 0; k < count; k++) begin
        // The channel carried in the top data bits must agree with dest
        check_reg("dest", REG_WIDTH'(wr_log[wr_start + k].sample.dest),
                  REG_WIDTH'(wr_log[wr_start + k].sample.data[DATA_WIDTH-1 -: DEST_WIDTH]));
        want.we     = 1'b1;
        want.addr   = base + ADDR_WIDTH'(k);
        want.sample = exp_q[k];
        check_mem($sformatf("mem write %0d", k), wr_log[wr_start + k], want);
    end
endtask

// Each wait is a loop that gives up after its own limit
task automatic wait_writes(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (wr_log.size() - wr_start < count) begin
        if (cycles >= limit) begin
            stop_with_error($sformatf("timeout waiting for %0d memory writes", count));
        end
        next_cycle();
        cycles++;
    end
endtask

task automatic wait_done(input int limit);
    int cycles;
    cycles = 0;
    while (done_count == done_start) begin
        if (cycles >= limit) begin
            stop_with_error("timeout waiting for dma_done");
        end
        next_cycle();
        cycles++;
    end
endtask

// Polls the status register until the hub reaches the wanted state
task automatic wait_state(input trigger_state_t want, input int limit);
    logic [REG_WIDTH-1:0] rd;
    int                   tries;
    tries = 0;
    reg_read(REG_STATUS, rd);
    while (trigger_state_t'(rd[1:0]) != want) begin
        if (tries >= limit) begin
            stop_with_error($sformatf("timeout waiting for hub state %s", want.name()));
        end
        reg_read(REG_STATUS, rd);
        tries++;
    end
endtask

`endif

//--- verif/scope_tb.sv
// Directed tests of the capture path with a 10 ns clock, the memory model accepts every write
`timescale 1ns/10ps

module scope_tb import scope_cfg_pkg::*, scope_stream_pkg::*; ();

    logic                  clock = 1'b0;
    logic                  rst_n;
    reg_bus_t              reg_bus;
    logic [REG_WIDTH-1:0]  reg_rdata;
    logic [N_STREAMS-1:0]  in_valid;
    sample_t               in_sample [N_STREAMS];
    logic [N_TRIGGERS-1:0] trigger_in;
    logic [N_TRIGGERS-1:0] trigger_out;
    mem_write_t            mem;
    logic                  dma_done;

    // Memory model and event logs, filled on the falling edge
    sample_t               mem_store [logic [ADDR_WIDTH-1:0]];
    mem_write_t            wr_log [$];
    logic [N_TRIGGERS-1:0] trig_log [$];
    int                    done_count = 0;

    // Expected writes in order, and where the current window starts in each log
    sample_t               exp_q [$];
    int                    wr_start;
    int                    trig_start;
    int                    done_start;

    int                    seed;
    int                    rr_ptr;
    int                    next_ch;
    logic [5:0]            run_count [N_STREAMS];
    logic [ADDR_WIDTH-1:0] base;

    always #5 clock = ~clock;

    scope_top scope_inst (
        .clock, .rst_n, .reg_bus, .reg_rdata, .in_valid, .in_sample,
        .trigger_in, .trigger_out, .mem, .dma_done
    );

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clock) begin
        if (rst_n && mem.we) begin
            wr_log.push_back(mem);
            mem_store[mem.addr] = mem.sample;
        end
        if (rst_n && dma_done) begin
            done_count++;
        end
        if (rst_n && trigger_out != '0) begin
            trig_log.push_back(trigger_out);
        end
    end

    `include "scope_checks.svh"

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Every task starts and ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        reg_bus = '{write: 1'b1, read: 1'b0, addr: addr, wdata: data};
        next_cycle();
        reg_bus = '0;
    endtask

    // Read data is registered on the edge that samples the read strobe
    task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        reg_bus = '{write: 1'b0, read: 1'b1, addr: addr, wdata: '0};
        next_cycle();
        reg_bus = '0;
        data = reg_rdata;
    endtask

    task automatic clear_logs();
        exp_q.delete();
        wr_start   = wr_log.size();
        trig_start = trig_log.size();
        done_start = done_count;
    endtask

    // Channel number in the top bits, a running count, then random bits
    task automatic build_sample(input int c, output sample_t s);
        logic [31:0] rnd;
        rnd = $random(seed);
        s.dest = DEST_WIDTH'(N_STREAMS - 1 - c);
        s.data = {c[1:0], run_count[c], rnd[7:0]};
        run_count[c] = run_count[c] + 1'b1;
    endtask

    // Strobes the masked channels for one cycle, the combiner must be empty
    task automatic strobe(input logic [N_STREAMS-1:0] mask);
        sample_t s;
        int      c;
        int      last;
        last = rr_ptr;
        for (int k = 0; k < N_STREAMS; k++) begin
            c = (rr_ptr + k) % N_STREAMS;
            if (mask[c]) begin
                build_sample(c, s);
                in_sample[c] = s;
                // Served from the pointer upward, with dest replaced by the channel
                s.dest = DEST_WIDTH'(c);
                exp_q.push_back(s);
                last = c;
            end
        end
        rr_ptr = (last + 1) % N_STREAMS;
        in_valid = mask;
        next_cycle();
        in_valid = '0;
    endtask

    // One channel per cycle in rotation, so no channel strobes while occupied
    task automatic stream_singles(input int n);
        for (int i = 0; i < n; i++) begin
            strobe(N_STREAMS'(1) << next_ch);
            next_ch = (next_ch + 1) % N_STREAMS;
        end
    endtask

    task automatic pulse_trigger(input int line);
        trigger_in[line] = 1'b1;
        next_cycle();
        next_cycle();
        trigger_in[line] = 1'b0;
        next_cycle();
    endtask

    task automatic start_capture();
        reg_write(REG_SW_TRIGGER, 32'd1);
        wait_state(TRIGGERED, 20);
        clear_logs();
    endtask

    task automatic test_register_access();
        logic [31:0] rd;
        check_reg("mem.we", REG_WIDTH'(mem.we), '0);
        check_reg("dma_done", REG_WIDTH'(dma_done), '0);
        check_trig("trigger_out", trigger_out, '0);
        reg_read(REG_BUFFER_SIZE, rd);
        check_reg("buffer_size", rd, 32'd32);
        reg_read(REG_STATUS, rd);
        check_state("status", trigger_state_t'(rd[1:0]), IDLE);
        reg_write(REG_BASE_ADDR, base);
        reg_read(REG_BASE_ADDR, rd);
        check_reg("base_addr", rd, base);
        reg_write(REG_SELECTED_TRIGGER, 32'd5);
        reg_read(REG_SELECTED_TRIGGER, rd);
        check_reg("selected_trigger", rd, 32'd5);
        reg_write(REG_ENABLE, 32'd1);
        reg_read(REG_ENABLE, rd);
        check_reg("enable", rd, 32'd1);
        reg_read(REG_CAPTURE_ACK, rd);
        check_reg("capture_ack", rd, '0);
        reg_read(REG_SW_TRIGGER, rd);
        check_reg("sw_trigger", rd, '0);
        wait_state(ARMED, 20);
    endtask

    task automatic test_sw_capture();
        logic [31:0] rd;
        start_capture();
        stream_singles(TRANSFER_SIZE);
        wait_writes(TRANSFER_SIZE, 200);
        wait_done(20);
        repeat (4) next_cycle();
        check_frame(TRANSFER_SIZE);
        check_reg("dma_done pulses", REG_WIDTH'(done_count - done_start), 32'd1);
        reg_read(REG_STATUS, rd);
        check_state("status", trigger_state_t'(rd[1:0]), HOLD);
    endtask

    task automatic test_round_robin();
        reg_write(REG_CAPTURE_ACK, 32'd1);
        wait_state(ARMED, 20);
        start_capture();
        strobe('1);
        wait_writes(N_STREAMS, 40);
        // Consecutive writes step through the channels and wrap after the last one
        for (int k = 0; k < N_STREAMS - 1; k++) begin
            check_reg("rotation", REG_WIDTH'(wr_log[wr_start + k + 1].sample.dest),
                      REG_WIDTH'((int'(wr_log[wr_start + k].sample.dest) + 1) % N_STREAMS));
        end
        check_frame(N_STREAMS);
        // Fill the rest of the frame so every strobed sample is accounted for
        stream_singles(TRANSFER_SIZE - N_STREAMS);
        wait_writes(TRANSFER_SIZE, 200);
        wait_done(20);
        check_frame(TRANSFER_SIZE);
        wait_state(HOLD, 20);
    endtask

    task automatic test_hold_ack();
        clear_logs();
        stream_singles(N_STREAMS);
        repeat (8) next_cycle();
        check_reg("writes in HOLD", REG_WIDTH'(wr_log.size() - wr_start), '0);
        reg_write(REG_CAPTURE_ACK, 32'd1);
        wait_state(ARMED, 20);
        start_capture();
        stream_singles(TRANSFER_SIZE);
        wait_writes(TRANSFER_SIZE, 200);
        wait_done(20);
        // The new frame overwrites the old one from base upward
        check_reg("memory at base", REG_WIDTH'(mem_store[base]), REG_WIDTH'(exp_q[0]));
        check_frame(TRANSFER_SIZE);
        wait_state(HOLD, 20);
    endtask

    task automatic test_ext_trigger();
        logic [31:0] rd;
        reg_write(REG_CAPTURE_ACK, 32'd1);
        wait_state(ARMED, 20);
        reg_write(REG_SELECTED_TRIGGER, 32'd5);
        clear_logs();
        pulse_trigger(3);
        reg_read(REG_STATUS, rd);
        check_state("status", trigger_state_t'(rd[1:0]), ARMED);
        check_reg("trigger pulses", REG_WIDTH'(trig_log.size() - trig_start), '0);
        // Armed samples run through the frame counter without being written
        stream_singles(5);
        repeat (6) next_cycle();
        check_reg("writes in ARMED", REG_WIDTH'(wr_log.size() - wr_start), '0);
        pulse_trigger(5);
        wait_state(TRIGGERED, 20);
        check_reg("trigger pulses", REG_WIDTH'(trig_log.size() - trig_start), 32'd1);
        check_trig("trigger_out", trig_log[trig_start], 8'h20);
        reg_read(REG_TRIGGER_SAMPLE, rd);
        check_reg("trigger_sample", rd, 32'd5);
    endtask

    task automatic test_disable();
        clear_logs();
        stream_singles(3);
        wait_writes(3, 40);
        check_frame(3);
        reg_write(REG_ENABLE, 32'd0);
        wait_state(IDLE, 20);
        clear_logs();
        stream_singles(N_STREAMS);
        repeat (8) next_cycle();
        check_reg("writes when disabled", REG_WIDTH'(wr_log.size() - wr_start), '0);
    endtask

    initial begin
        seed       = 44237;
        rst_n      = 1'b0;
        reg_bus    = '0;
        in_valid   = '0;
        trigger_in = '0;
        for (int c = 0; c < N_STREAMS; c++) begin
            in_sample[c] = '0;
            run_count[c] = '0;
        end
        rr_ptr  = 0;
        next_ch = 0;
        base    = 32'h0000_1000;
        clear_logs();
        repeat (4) @(posedge clock);
        #1;
        rst_n = 1'b1;
        test_register_access();
        test_sw_capture();
        test_round_robin();
        test_hold_ack();
        test_ext_trigger();
        test_disable();
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verilog/sample_counter.sv
// Frames are counted from the first beat after inhibit drops, so captures start on a boundary
`timescale 1ns/10ps

module sample_counter import scope_cfg_pkg::*, scope_stream_pkg::*; (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   capture_inhibit,
    input  stream_beat_t           beat_in,
    output stream_beat_t           beat_out,
    output logic [LEVEL_WIDTH-1:0] buffer_level,
    output logic                   frame_end
);

    logic [LEVEL_WIDTH-1:0] count;
    logic                   valid_q;
    logic                   last_q;
    sample_t                sample_q;
    logic                   at_end;

    assign at_end = (count == LEVEL_WIDTH'(TRANSFER_SIZE - 1));

    always_ff @(posedge clock) begin
        if (!rst_n || capture_inhibit) begin
            // Inhibit drops the beat and rewinds the frame
            count   <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= beat_in.valid;
            last_q  <= beat_in.valid && at_end;
            if (beat_in.valid) begin
                count <= at_end ? '0 : count + 1'b1;
            end
        end
    end

    // Sample payload follows the valid beat
    always_ff @(posedge clock) begin
        if (beat_in.valid) begin
            sample_q <= beat_in.sample;
        end
    end

    assign beat_out     = '{valid: valid_q, last: last_q, sample: sample_q};
    assign frame_end    = valid_q && last_q;
    assign buffer_level = count;

endmodule

//--- verilog/scope_regs.sv
// Read data is valid one cycle after the read strobe and read and write never share a cycle
`timescale 1ns/10ps

module scope_regs import scope_cfg_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  reg_bus_t                  bus,
    output logic [REG_WIDTH-1:0]      rdata,
    input  trigger_state_t            state,
    input  logic [LEVEL_WIDTH-1:0]    trigger_sample,
    output logic                      enable,
    output logic [REG_WIDTH-1:0]      base_addr,
    output logic [TRIG_SEL_WIDTH-1:0] selected_trigger,
    output logic                      capture_ack,
    output logic                      sw_trigger
);

    logic wr_ack;
    logic wr_sw_trigger;

    // The strobe registers react to any write, the data is ignored
    assign wr_ack        = bus.write && (bus.addr == REG_CAPTURE_ACK);
    assign wr_sw_trigger = bus.write && (bus.addr == REG_SW_TRIGGER);

    // Control registers and the two command pulses
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            enable           <= 1'b0;
            base_addr        <= '0;
            selected_trigger <= '0;
            capture_ack      <= 1'b0;
            sw_trigger       <= 1'b0;
        end else begin
            // Pulses last exactly one cycle after the write
            capture_ack <= wr_ack;
            sw_trigger  <= wr_sw_trigger;
            if (bus.write) begin
                case (bus.addr)
                    REG_ENABLE:           enable <= bus.wdata[0];
                    REG_BASE_ADDR:        base_addr <= bus.wdata;
                    REG_SELECTED_TRIGGER: selected_trigger <= bus.wdata[TRIG_SEL_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data is only updated on a read, it holds between reads
    always_ff @(posedge clock) begin
        if (bus.read) begin
            case (bus.addr)
                REG_BUFFER_SIZE:      rdata <= REG_WIDTH'(TRANSFER_SIZE);
                REG_ENABLE:           rdata <= REG_WIDTH'(enable);
                REG_BASE_ADDR:        rdata <= base_addr;
                REG_SELECTED_TRIGGER: rdata <= REG_WIDTH'(selected_trigger);
                REG_TRIGGER_SAMPLE:   rdata <= REG_WIDTH'(trigger_sample);
                REG_STATUS:           rdata <= REG_WIDTH'(state);
                // Ack and software trigger are write strobes and read as zero
                default:              rdata <= '0;
            endcase
        end
    end

    // A bus master issues either a read or a write in a cycle, never both
    a_no_read_write: assert property (
        @(posedge clock) disable iff (!rst_n) !(bus.read && bus.write)
    );

endmodule

//--- verilog/scope_top.sv
// All blocks share one clock and reset, trigger lines and channel strobes must be synchronous
`timescale 1ns/10ps

module scope_top import scope_cfg_pkg::*, scope_stream_pkg::*; (
    input  logic                  clock,
    input  logic                  rst_n,
    input  reg_bus_t              reg_bus,
    output logic [REG_WIDTH-1:0]  reg_rdata,
    input  logic [N_STREAMS-1:0]  in_valid,
    input  sample_t               in_sample [N_STREAMS],
    input  logic [N_TRIGGERS-1:0] trigger_in,
    output logic [N_TRIGGERS-1:0] trigger_out,
    output mem_write_t            mem,
    output logic                  dma_done
);

    logic                      enable;
    logic [REG_WIDTH-1:0]      base_addr;
    logic [TRIG_SEL_WIDTH-1:0] selected_trigger;
    logic                      capture_ack;
    logic                      sw_trigger;
    trigger_state_t            state;
    logic [LEVEL_WIDTH-1:0]    trigger_sample;
    logic [LEVEL_WIDTH-1:0]    buffer_level;
    logic                      capture_inhibit;
    logic                      frame_end;
    stream_beat_t              merged;
    stream_beat_t              framed;

    scope_regs regs_inst (
        .clock, .rst_n, .bus(reg_bus), .rdata(reg_rdata), .state, .trigger_sample,
        .enable, .base_addr, .selected_trigger, .capture_ack, .sw_trigger
    );

    trigger_hub hub_inst (
        .clock, .rst_n, .enable, .selected_trigger, .trigger_in, .sw_trigger,
        .capture_ack, .buffer_level, .frame_end, .state, .trigger_sample,
        .capture_inhibit, .trigger_out
    );

    // Channels are merged into one stream before framing
    stream_combiner combiner_inst (
        .clock, .rst_n, .in_valid, .in_sample, .beat_out(merged)
    );

    sample_counter counter_inst (
        .clock, .rst_n, .capture_inhibit, .beat_in(merged), .beat_out(framed),
        .buffer_level, .frame_end
    );

    // Memory writes happen only while the hub holds a live capture
    buffer_writer writer_inst (
        .clock, .rst_n, .enable, .capture_active(state == TRIGGERED),
        .base_addr, .beat_in(framed), .mem, .dma_done
    );

endmodule

//--- verilog/stream_combiner.sv
// A channel may strobe only after its held sample has left, merged output is combinational
`timescale 1ns/10ps

module stream_combiner import scope_cfg_pkg::*, scope_stream_pkg::*; (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [N_STREAMS-1:0] in_valid,
    input  sample_t              in_sample [N_STREAMS],
    output stream_beat_t         beat_out
);

    localparam int PTR_WIDTH = $clog2(N_STREAMS);

    logic [N_STREAMS-1:0] held_valid;
    sample_t              held [N_STREAMS];
    logic [PTR_WIDTH-1:0] ptr;
    logic [PTR_WIDTH-1:0] sel;
    logic                 found;
    logic [N_STREAMS-1:0] grant;

    // First occupied holding register at or after the pointer
    always_comb begin
        int idx;
        sel   = ptr;
        found = 1'b0;
        for (int k = 0; k < N_STREAMS; k++) begin
            idx = (int'(ptr) + k) % N_STREAMS;
            if (!found && held_valid[idx]) begin
                sel   = PTR_WIDTH'(idx);
                found = 1'b1;
            end
        end
    end

    assign grant    = found ? (N_STREAMS'(1) << sel) : '0;
    assign beat_out = '{valid: found, last: 1'b0, sample: held[sel]};

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held_valid <= '0;
            ptr        <= '0;
        end else begin
            held_valid <= in_valid | (held_valid & ~grant);
            // Move past the channel just served so every channel gets its turn
            if (found) begin
                ptr <= (sel == PTR_WIDTH'(N_STREAMS - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    // Holding registers, the dest field is replaced by the channel number
    always_ff @(posedge clock) begin
        for (int i = 0; i < N_STREAMS; i++) begin
            if (in_valid[i]) begin
                held[i] <= '{dest: DEST_WIDTH'(i), data: in_sample[i].data};
            end
        end
    end

    // A new strobe on an occupied channel would overwrite an unsent sample
    a_no_overrun: assert property (
        @(posedge clock) disable iff (!rst_n) (in_valid & held_valid) == '0
    );

endmodule

//--- verilog/trigger_hub.sv
// Trigger lines must be synchronous to clock and only one capture is outstanding at a time
`timescale 1ns/10ps

module trigger_hub import scope_cfg_pkg::*; (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [TRIG_SEL_WIDTH-1:0] selected_trigger,
    input  logic [N_TRIGGERS-1:0]     trigger_in,
    input  logic                      sw_trigger,
    input  logic                      capture_ack,
    input  logic [LEVEL_WIDTH-1:0]    buffer_level,
    input  logic                      frame_end,
    output trigger_state_t            state,
    output logic [LEVEL_WIDTH-1:0]    trigger_sample,
    output logic                      capture_inhibit,
    output logic [N_TRIGGERS-1:0]     trigger_out
);

    logic [N_TRIGGERS-1:0] trigger_q;
    logic                  ext_edge;
    logic                  fire;

    // Rising edge on the selected external line only
    assign ext_edge = trigger_in[selected_trigger] && !trigger_q[selected_trigger];

    // A trigger is only taken while armed, otherwise it is lost
    assign fire = (state == ARMED) && (ext_edge || sw_trigger);

    // Samples pass to memory only outside IDLE and HOLD
    // In ARMED they still cycle through the frame counter
    assign capture_inhibit = (state == IDLE) || (state == HOLD);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state          <= IDLE;
            trigger_q      <= '0;
            trigger_sample <= '0;
            trigger_out    <= '0;
        end else begin
            trigger_q <= trigger_in;
            // One cycle pulse on the line that fired, also for a software trigger
            trigger_out <= fire ? (N_TRIGGERS'(1) << selected_trigger) : '0;
            if (fire) begin
                trigger_sample <= buffer_level;
            end
            if (!enable) begin
                // Disable overrides every state
                state <= IDLE;
            end else begin
                case (state)
                    IDLE:      state <= ARMED;
                    ARMED:     if (fire) state <= TRIGGERED;
                    TRIGGERED: if (frame_end) state <= HOLD;
                    // Wait for software to take the buffer before re-arming
                    HOLD:      if (capture_ack) state <= ARMED;
                    default:   state <= IDLE;
                endcase
            end
        end
    end

endmodule
